// ==== design/tcm_consts.svh ====
// width, depth and credit macros for the shared TCM

`ifndef TCM_CONSTS_SVH
`define TCM_CONSTS_SVH

// word addressing, one RAM word per address
`define TCM_ADDR_WIDTH 8
`define TCM_DEPTH 256

// data word and its byte lanes
`define TCM_DATA_WIDTH 32
`define TCM_STRB_WIDTH 4

// bits per strobe lane
`define TCM_BYTE_WIDTH 8

// credits handed to each requester after reset
// also the depth of each ingress queue
`define TCM_PORT_CREDITS 2

`endif

// ==== design/tcm_pkg.sv ====
// address, data, strobe, request struct and port select types for the TCM

`include "tcm_consts.svh"

package tcm_pkg;

    typedef logic [`TCM_ADDR_WIDTH-1:0] addr_t;   // word address
    typedef logic [`TCM_DATA_WIDTH-1:0] data_t;
    typedef logic [`TCM_STRB_WIDTH-1:0] strb_t;   // one bit per byte lane

    // instruction fetch, read only
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // load or store from the execution side
    typedef struct packed {
        logic  we;      // set for a store
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } data_req_t;

    // which peer owns a RAM access
    typedef enum logic {
        FETCH_PORT = 1'b0,
        DATA_PORT  = 1'b1
    } port_sel_e;

endpackage

// ==== design/tcm_port_if.sv ====
// tcm_port_if: link between one ingress queue and the arbiter

`timescale 1ns/1ps

`include "tcm_consts.svh"

interface tcm_port_if #(
    parameter type REQ_T = tcm_pkg::fetch_req_t
);

    // queue head, owned by the ingress side
    logic head_valid;   // queue not empty
    REQ_T head_req;     // oldest request

    // arbiter side
    logic           grant;      // head consumed this cycle
    logic           rsp_valid;  // read data for this port
    tcm_pkg::data_t rsp_data;

    modport ingress (
        output head_valid,
        output head_req,
        input  grant,
        input  rsp_valid,
        input  rsp_data
    );

    modport arbiter (
        input  head_valid,
        input  head_req,
        output grant,
        output rsp_valid,
        output rsp_data
    );

endinterface

// ==== design/port_ingress.sv ====
// port_ingress: credit managed request queue with response pin drive

`timescale 1ns/1ps

`include "tcm_consts.svh"

module port_ingress #(
    parameter type REQ_T = tcm_pkg::fetch_req_t
) (
    input  wire            clk,
    input  wire            rst_n_i,

    // requester side
    input  wire            req_valid_i,  // only sent while a credit is held
    input  REQ_T           req_i,
    output logic           credit_o,     // one pulse per dequeued entry
    output logic           rsp_valid_o,
    output tcm_pkg::data_t rsp_data_o,

    tcm_port_if.ingress    port
);

    localparam int DEPTH = `TCM_PORT_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    REQ_T             mem_q [DEPTH];  // payload slots
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             credit_q;

    wire push = req_valid_i;
    wire pop  = port.grant;  // arbiter only grants a valid head

    // payload write, no reset needed
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end

            if (push && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - CNT_W'(1);
            end

            // slot freed at this edge, credit goes back next cycle
            credit_q <= pop;
        end
    end

    assign port.head_valid = (count_q != '0);
    assign port.head_req   = mem_q[rd_ptr_q];

    assign credit_o = credit_q;

    // response path of the same port
    assign rsp_valid_o = port.rsp_valid;
    assign rsp_data_o  = port.rsp_data;

endmodule

// ==== design/tcm_arbiter.sv ====
// tcm_arbiter: round-robin grant, RAM command and read response steering

`timescale 1ns/1ps

`include "tcm_consts.svh"

module tcm_arbiter (
    input  wire             clk,
    input  wire             rst_n_i,

    tcm_port_if.arbiter     fetch,
    tcm_port_if.arbiter     data,

    // single-port RAM command
    output logic            ram_en_o,
    output logic            ram_we_o,
    output tcm_pkg::addr_t  ram_addr_o,
    output tcm_pkg::data_t  ram_wdata_o,
    output tcm_pkg::strb_t  ram_strb_o,
    input  tcm_pkg::data_t  ram_rdata_i
);

    tcm_pkg::port_sel_e last_q;      // winner of the previous contended or lone grant
    tcm_pkg::port_sel_e win_sel;
    tcm_pkg::port_sel_e infl_sel_q;  // owner of the access now in the RAM
    logic               infl_rd_q;   // that access returns data
    logic               fetch_win;
    logic               data_win;

    always_comb begin
        fetch_win = 1'b0;
        data_win  = 1'b0;
        if (fetch.head_valid && data.head_valid) begin
            // contention, the other side goes first
            if (last_q == tcm_pkg::FETCH_PORT) begin
                data_win = 1'b1;
            end else begin
                fetch_win = 1'b1;
            end
        end else begin
            fetch_win = fetch.head_valid;
            data_win  = data.head_valid;
        end
    end

    assign win_sel = data_win ? tcm_pkg::DATA_PORT : tcm_pkg::FETCH_PORT;

    assign fetch.grant = fetch_win;
    assign data.grant  = data_win;

    // fetches never write
    assign ram_en_o    = fetch_win | data_win;
    assign ram_we_o    = data_win & data.head_req.we;
    assign ram_addr_o  = data_win ? data.head_req.addr : fetch.head_req.addr;
    assign ram_wdata_o = data.head_req.wdata;
    assign ram_strb_o  = data_win ? data.head_req.strb : {`TCM_STRB_WIDTH{1'b0}};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q     <= tcm_pkg::DATA_PORT;  // fetch wins the first tie
            infl_sel_q <= tcm_pkg::FETCH_PORT;
            infl_rd_q  <= 1'b0;
        end else begin
            if (ram_en_o) begin
                last_q <= win_sel;
            end
            infl_sel_q <= win_sel;
            infl_rd_q  <= ram_en_o & ~ram_we_o;  // stores get no response
        end
    end

    // RAM data lands one cycle after the grant
    assign fetch.rsp_valid = infl_rd_q && (infl_sel_q == tcm_pkg::FETCH_PORT);
    assign data.rsp_valid  = infl_rd_q && (infl_sel_q == tcm_pkg::DATA_PORT);
    assign fetch.rsp_data  = ram_rdata_i;
    assign data.rsp_data   = ram_rdata_i;

endmodule

// ==== design/tcm_ram.sv ====
// tcm_ram: single-port word RAM, byte strobed write, registered read

`timescale 1ns/1ps

`include "tcm_consts.svh"

module tcm_ram (
    input  wire             clk,
    input  wire             en_i,
    input  wire             we_i,
    input  tcm_pkg::addr_t  addr_i,
    input  tcm_pkg::data_t  wdata_i,
    input  tcm_pkg::strb_t  strb_i,
    output tcm_pkg::data_t  rdata_o
);

    localparam int BW = `TCM_BYTE_WIDTH;

    tcm_pkg::data_t mem [`TCM_DEPTH];  // contents undefined until written
    tcm_pkg::data_t rdata_q;

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                // only the enabled lanes change
                for (int b = 0; b < `TCM_STRB_WIDTH; b++) begin
                    if (strb_i[b]) begin
                        mem[addr_i][b*BW +: BW] <= wdata_i[b*BW +: BW];
                    end
                end
            end else begin
                rdata_q <= mem[addr_i];  // valid the next cycle
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== design/tcm_top.sv ====
// tcm_top: fetch and data ingress queues, round-robin arbiter and shared RAM

`timescale 1ns/1ps

`include "tcm_consts.svh"

module tcm_top (
    input  wire             clk,
    input  wire             rst_n_i,

    // fetch port, read only
    input  wire             fetch_req_valid_i,
    input  tcm_pkg::addr_t  fetch_addr_i,
    output logic            fetch_credit_o,
    output logic            fetch_rsp_valid_o,
    output tcm_pkg::data_t  fetch_rdata_o,

    // data port, loads and stores
    input  wire             data_req_valid_i,
    input  wire             data_we_i,
    input  tcm_pkg::addr_t  data_addr_i,
    input  tcm_pkg::data_t  data_wdata_i,
    input  tcm_pkg::strb_t  data_strb_i,
    output logic            data_credit_o,
    output logic            data_rsp_valid_o,
    output tcm_pkg::data_t  data_rdata_o
);

    tcm_pkg::fetch_req_t fetch_req;
    tcm_pkg::data_req_t  data_req;

    // RAM command from the arbiter
    logic           ram_en;
    logic           ram_we;
    tcm_pkg::addr_t ram_addr;
    tcm_pkg::data_t ram_wdata;
    tcm_pkg::strb_t ram_strb;
    tcm_pkg::data_t ram_rdata;

    tcm_port_if #(.REQ_T(tcm_pkg::fetch_req_t)) fetch_if ();
    tcm_port_if #(.REQ_T(tcm_pkg::data_req_t))  data_if ();

    // pins into request structs
    assign fetch_req.addr = fetch_addr_i;

    assign data_req.we    = data_we_i;
    assign data_req.addr  = data_addr_i;
    assign data_req.wdata = data_wdata_i;
    assign data_req.strb  = data_strb_i;

    port_ingress #(
        .REQ_T(tcm_pkg::fetch_req_t)
    ) u_fetch_ingress (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_valid_i(fetch_req_valid_i),
        .req_i      (fetch_req),
        .credit_o   (fetch_credit_o),
        .rsp_valid_o(fetch_rsp_valid_o),
        .rsp_data_o (fetch_rdata_o),
        .port       (fetch_if.ingress)
    );

    port_ingress #(
        .REQ_T(tcm_pkg::data_req_t)
    ) u_data_ingress (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_valid_i(data_req_valid_i),
        .req_i      (data_req),
        .credit_o   (data_credit_o),
        .rsp_valid_o(data_rsp_valid_o),
        .rsp_data_o (data_rdata_o),
        .port       (data_if.ingress)
    );

    tcm_arbiter u_arbiter (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch      (fetch_if.arbiter),
        .data       (data_if.arbiter),
        .ram_en_o   (ram_en),
        .ram_we_o   (ram_we),
        .ram_addr_o (ram_addr),
        .ram_wdata_o(ram_wdata),
        .ram_strb_o (ram_strb),
        .ram_rdata_i(ram_rdata)
    );

    // one RAM shared by both peers
    tcm_ram u_ram (
        .clk    (clk),
        .en_i   (ram_en),
        .we_i   (ram_we),
        .addr_i (ram_addr),
        .wdata_i(ram_wdata),
        .strb_i (ram_strb),
        .rdata_o(ram_rdata)
    );

endmodule

// ==== tests/tb_tcm_top.sv ====
// tb_tcm_top: clock, reset, golden file driver, saturation phase, checks and timeout

`timescale 1ns/1ps

`include "tcm_consts.svh"

module tb_tcm_top;

    localparam int CREDITS   = `TCM_PORT_CREDITS;
    localparam int MAX_OPS   = 64;
    localparam int SAT_READS = 24;  // reads per port while both are saturated

    logic           clk;
    logic           rst_n_i;
    logic           fetch_req_valid_i;
    tcm_pkg::addr_t fetch_addr_i;
    logic           fetch_credit_o;
    logic           fetch_rsp_valid_o;
    tcm_pkg::data_t fetch_rdata_o;
    logic           data_req_valid_i;
    logic           data_we_i;
    tcm_pkg::addr_t data_addr_i;
    tcm_pkg::data_t data_wdata_i;
    tcm_pkg::strb_t data_strb_i;
    logic           data_credit_o;
    logic           data_rsp_valid_o;
    tcm_pkg::data_t data_rdata_o;

    logic [31:0]    golden [MAX_OPS*6];  // six fields per operation
    tcm_pkg::data_t model_mem [`TCM_DEPTH];
    bit             is_written [`TCM_DEPTH];
    tcm_pkg::addr_t written_q[$];
    tcm_pkg::data_t fetch_exp_q[$];
    tcm_pkg::data_t data_exp_q[$];
    bit             data_we_q[$];        // store flag per data request in the queue
    int             fetch_sent, data_sent, fetch_returned, data_returned;
    int             stores_sent, stores_done;
    int             sat_fetch_rsp, sat_data_rsp, max_diff;
    int             num_ops, cycle_cnt, cycle_limit;
    bit             saturating;
    logic [31:0]    lcg_state;
    string          phase_name;

    tcm_top UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    function automatic int fetch_avail();
        return CREDITS - fetch_sent + fetch_returned;
    endfunction

    function automatic int data_avail();
        return CREDITS - data_sent + data_returned;
    endfunction

    task automatic check_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic send_fetch(tcm_pkg::addr_t addr, tcm_pkg::data_t exp_val);
        fetch_req_valid_i <= 1'b1;
        fetch_addr_i      <= addr;
        fetch_sent++;
        fetch_exp_q.push_back(exp_val);
    endtask

    task automatic send_data(logic we, tcm_pkg::addr_t addr, tcm_pkg::data_t wdata,
                             tcm_pkg::strb_t strb, tcm_pkg::data_t exp_val);
        data_req_valid_i <= 1'b1;
        data_we_i        <= we;
        data_addr_i      <= addr;
        data_wdata_i     <= wdata;
        data_strb_i      <= strb;
        data_sent++;
        data_we_q.push_back(we);
        if (we) begin
            stores_sent++;
            // memory model keeps only the enabled bytes
            for (int b = 0; b < `TCM_STRB_WIDTH; b++) begin
                if (strb[b]) model_mem[addr][b*8 +: 8] = wdata[b*8 +: 8];
            end
            if (!is_written[addr]) begin
                is_written[addr] = 1'b1;
                written_q.push_back(addr);
            end
        end else begin
            data_exp_q.push_back(exp_val);
        end
    endtask

    // fetch waits for stores in flight, a store waits for fetches in flight
    function automatic bit can_issue(int i);
        if (golden[i*6] == 0) begin
            return fetch_avail() > 0 && stores_sent == stores_done;
        end else if (golden[i*6+1] != 0) begin
            return data_avail() > 0 && fetch_avail() == CREDITS;
        end else begin
            return data_avail() > 0;
        end
    endfunction

    task automatic issue_line(int i);
        tcm_pkg::addr_t addr;
        addr = golden[i*6+2][`TCM_ADDR_WIDTH-1:0];
        if (golden[i*6+1] == 0) begin
            check_value($sformatf("golden line %0d vs memory model", i), model_mem[addr],
                        golden[i*6+5]);
        end
        if (golden[i*6] == 0) begin
            send_fetch(addr, golden[i*6+5]);
        end else begin
            send_data(golden[i*6+1][0], addr, golden[i*6+3],
                      golden[i*6+4][`TCM_STRB_WIDTH-1:0], golden[i*6+5]);
        end
    endtask

    // a read's credit comes with its response, stores only return a credit
    task automatic wait_drain();
        while (fetch_exp_q.size() != 0 || data_exp_q.size() != 0 ||
               stores_sent != stores_done) begin
            @(posedge clk);
            fetch_req_valid_i <= 1'b0;
            data_req_valid_i  <= 1'b0;
        end
    endtask

    // outputs sampled mid cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (fetch_credit_o) fetch_returned++;
            if (fetch_returned > fetch_sent) stop_with_error("fetch credit without a request");
            if (data_credit_o) begin
                if (data_we_q.size() == 0) begin
                    stop_with_error("data credit without a request");
                end else begin
                    if (data_we_q.pop_front()) stores_done++;
                    data_returned++;
                end
            end
            if (fetch_rsp_valid_o) begin
                if (fetch_exp_q.size() == 0) begin
                    stop_with_error("fetch response with no outstanding read");
                end else begin
                    check_value({phase_name, " fetch read"}, fetch_exp_q.pop_front(),
                                fetch_rdata_o);
                    if (saturating) sat_fetch_rsp++;
                end
            end
            if (data_rsp_valid_o) begin
                if (data_exp_q.size() == 0) begin
                    stop_with_error("data response with no outstanding load");
                end else begin
                    check_value({phase_name, " data load"}, data_exp_q.pop_front(),
                                data_rdata_o);
                    if (saturating) sat_data_rsp++;
                end
            end
            if (sat_fetch_rsp - sat_data_rsp > max_diff) max_diff = sat_fetch_rsp - sat_data_rsp;
            if (sat_data_rsp - sat_fetch_rsp > max_diff) max_diff = sat_data_rsp - sat_fetch_rsp;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_with_error("timeout, the DUT stopped returning credits or responses");
        end
    end

    initial begin
        int             idx;
        int             fetch_left;
        int             data_left;
        tcm_pkg::addr_t addr;
        clk               = 1'b0;
        rst_n_i           = 1'b0;
        fetch_req_valid_i = 1'b0;
        fetch_addr_i      = '0;
        data_req_valid_i  = 1'b0;
        data_we_i         = 1'b0;
        data_addr_i       = '0;
        data_wdata_i      = '0;
        data_strb_i       = '0;
        lcg_state         = 32'd8357;
        phase_name        = "reset";
        for (int i = 0; i < MAX_OPS*6; i++) golden[i] = '1;  // end marker
        $readmemh("tests/tcm_golden.hex", golden);
        while (num_ops < MAX_OPS && golden[num_ops*6] != '1) num_ops++;
        if (num_ops == 0) stop_with_error("golden file missing or empty");
        cycle_limit = 20 * num_ops + 400;

        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("reset fetch credit", 0, 32'(fetch_credit_o));
            check_value("reset data credit", 0, 32'(data_credit_o));
            check_value("reset fetch response", 0, 32'(fetch_rsp_valid_o));
            check_value("reset data response", 0, 32'(data_rsp_valid_o));
        end

        phase_name = "golden";
        idx = 0;
        while (idx < num_ops) begin
            @(posedge clk);
            fetch_req_valid_i <= 1'b0;
            data_req_valid_i  <= 1'b0;
            if (next_rand() % 4 != 0 && can_issue(idx)) begin  // random idle gaps
                issue_line(idx);
                idx++;
                // the other port may go in the same cycle
                if (idx < num_ops && golden[idx*6] != golden[(idx-1)*6] && can_issue(idx)) begin
                    issue_line(idx);
                    idx++;
                end
            end
        end
        wait_drain();

        phase_name = "saturation";
        saturating = 1'b1;
        fetch_left = SAT_READS;
        data_left  = SAT_READS;
        while (fetch_left > 0 || data_left > 0) begin
            @(posedge clk);
            fetch_req_valid_i <= 1'b0;
            data_req_valid_i  <= 1'b0;
            if (fetch_left > 0 && fetch_avail() > 0) begin
                addr = written_q[next_rand() % written_q.size()];
                send_fetch(addr, model_mem[addr]);
                fetch_left--;
            end
            if (data_left > 0 && data_avail() > 0) begin
                addr = written_q[next_rand() % written_q.size()];
                send_data(1'b0, addr, '0, '0, model_mem[addr]);
                data_left--;
            end
        end
        wait_drain();
        saturating = 1'b0;
        check_value("saturation fetch responses", SAT_READS, sat_fetch_rsp);
        check_value("saturation data responses", SAT_READS, sat_data_rsp);
        check_value("round robin balance within 2", 1, 32'(max_diff <= 2));

        phase_name = "end of run";
        check_value("fetch credits after drain", CREDITS, fetch_avail());
        check_value("data credits after drain", CREDITS, data_avail());
        @(posedge clk);
        send_fetch(written_q[0], model_mem[written_q[0]]);
        send_data(1'b0, written_q[1], '0, '0, model_mem[written_q[1]]);
        wait_drain();
        check_value("credit pulses vs requests", fetch_sent + data_sent,
                    fetch_returned + data_returned);

        if (fetch_exp_q.size() == 0 && data_exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_error("responses still outstanding at end of run");
        end
    end

endmodule

// ==== tests/tcm_golden.hex ====
// port(0 fetch, 1 data) we addr wdata strb expected_rdata
// expected_rdata is compared on reads only
1 1 10 11223344 f 00000000
1 1 11 55667788 f 00000000
1 1 12 99aabbcc f 00000000
1 1 13 deadbeef f 00000000
1 0 10 00000000 0 11223344
1 1 10 000000a5 1 00000000
1 0 10 00000000 0 112233a5
1 1 11 0000ee00 2 00000000
1 0 11 00000000 0 5566ee88
1 1 12 00770000 4 00000000
1 0 12 00000000 0 9977bbcc
1 1 13 c0000000 8 00000000
1 0 13 00000000 0 c0adbeef
1 1 10 12340000 c 00000000
1 0 10 00000000 0 123433a5
1 1 11 00009999 3 00000000
1 0 11 00000000 0 55669999
0 0 10 00000000 0 123433a5
0 0 11 00000000 0 55669999
0 0 12 00000000 0 9977bbcc
0 0 13 00000000 0 c0adbeef
1 1 20 00000013 f 00000000
1 1 21 00100093 f 00000000
1 1 22 00208113 f 00000000
1 1 23 0000006f f 00000000
0 0 20 00000000 0 00000013
1 0 12 00000000 0 9977bbcc
0 0 21 00000000 0 00100093
1 0 13 00000000 0 c0adbeef
0 0 22 00000000 0 00208113
1 0 20 00000000 0 00000013
0 0 23 00000000 0 0000006f
1 0 21 00000000 0 00100093
0 0 10 00000000 0 123433a5
1 0 22 00000000 0 00208113
1 1 23 ff000000 8 00000000
0 0 23 00000000 0 ff00006f
1 0 23 00000000 0 ff00006f

// ==== list.f ====
+incdir+design
design/tcm_pkg.sv
design/tcm_port_if.sv
design/port_ingress.sv
design/tcm_arbiter.sv
design/tcm_ram.sv
design/tcm_top.sv
tests/tb_tcm_top.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timescale 1ns/1ps -f list.f --top-module tb_tcm_top
	./obj_dir/Vtb_tcm_top | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
